// ==== filelist.f ====
src/ccc_pkg.sv
src/ccc_frame_parser.sv
src/ccc_record_fifo.sv
src/ccc_handler.sv
src/ccc_top.sv
verification/tb_clock.sv
verification/ccc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module ccc_tb -f filelist.f -o ccc_sim
out="$(./obj_dir/ccc_sim || true)"
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'NO ERRORS'; then
  exit 0
fi
exit 1

// ==== verification/ccc_tb.sv ====
// Runs the DUT with the default FIFO_DEPTH; table rows run one at a time, then two hold bursts
module ccc_tb;

  import ccc_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int NUM_ROWS   = 12;
  localparam int TIMEOUT    = 50;

  typedef enum logic [1:0] {RES_RESP, RES_HDR, RES_RST, RES_NONE} result_e;

  typedef struct packed {
    logic       send_code;
    logic [7:0] code;
    logic       has_def;
    logic [7:0] def_byte;
    logic [3:0] hold_cycles;
    result_e    kind;
  } row_t;

  logic         clk_i;
  logic         rst_ni;
  logic         frame_start_i;
  logic [7:0]   byte_i;
  logic         byte_valid_i;
  logic         frame_end_i;
  logic         response_hold_i;
  queue_sizes_t queue_size_i;
  logic [7:0]   response_byte_o;
  logic         response_valid_o;
  logic         enter_hdr_o;
  logic [7:0]   rst_action_o;
  logic         overflow_o;

  row_t        rows [NUM_ROWS];
  logic [31:0] rng_state;
  logic [7:0]  exp_rst;
  logic [7:0]  exp_q [$];

  tb_clock tb_clock_i (
    .clk_o (clk_i)
  );

  ccc_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) ccc_top_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .frame_start_i    (frame_start_i),
    .byte_i           (byte_i),
    .byte_valid_i     (byte_valid_i),
    .frame_end_i      (frame_end_i),
    .response_hold_i  (response_hold_i),
    .queue_size_i     (queue_size_i),
    .response_byte_o  (response_byte_o),
    .response_valid_o (response_valid_o),
    .enter_hdr_o      (enter_hdr_o),
    .rst_action_o     (rst_action_o),
    .overflow_o       (overflow_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic queue_sizes_t next_sizes();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // GETMRL reports the RX buffer, GETMWL the TX buffer
  function automatic logic [7:0] expected_byte(input logic [7:0] code, input queue_sizes_t sizes);
    return (code == CCC_GETMRL) ? sizes.rx_buf : sizes.tx_buf;
  endfunction

  task automatic fill_table();
    rows[0]  = '{1'b1, CCC_GETMRL, 1'b0, 8'h00, 4'd0, RES_RESP};
    rows[1]  = '{1'b1, CCC_GETMWL, 1'b0, 8'h00, 4'd0, RES_RESP};
    rows[2]  = '{1'b1, CCC_ENTHDR0, 1'b0, 8'h00, 4'd0, RES_HDR};
    rows[3]  = '{1'b1, CCC_RSTACT_BCAST, 1'b1, 8'h5A, 4'd0, RES_RST};
    rows[4]  = '{1'b1, CCC_RSTACT_DIRECT, 1'b1, 8'hC3, 4'd0, RES_RST};
    rows[5]  = '{1'b1, CCC_GETMRL, 1'b1, 8'h11, 4'd3, RES_RESP};
    // Stale defining byte from the frame before differs from the action
    rows[6]  = '{1'b1, CCC_RSTACT_BCAST, 1'b0, 8'h00, 4'd0, RES_NONE};
    rows[7]  = '{1'b1, CCC_ENTHDR0, 1'b0, 8'h00, 4'd2, RES_HDR};
    rows[8]  = '{1'b1, CCC_RSTACT_DIRECT, 1'b1, 8'h07, 4'd4, RES_RST};
    rows[9]  = '{1'b1, 8'h42, 1'b1, 8'h99, 4'd0, RES_NONE};
    rows[10] = '{1'b1, CCC_GETMWL, 1'b0, 8'h00, 4'd1, RES_RESP};
    // Code value on the bus but never strobed
    rows[11] = '{1'b0, CCC_GETMRL, 1'b0, 8'h00, 4'd0, RES_NONE};
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_response(input logic [7:0] exp_val, input logic [7:0] act_val);
    if (act_val !== exp_val) begin
      report_failure($sformatf("** Error @ %0t: response_byte_o expected 0x%02h, got 0x%02h",
                               $time, exp_val, act_val));
    end
  endtask

  task automatic check_rst_action(input logic [7:0] exp_val, input logic [7:0] act_val);
    if (act_val !== exp_val) begin
      report_failure($sformatf("** Error @ %0t: rst_action_o expected 0x%02h, got 0x%02h",
                               $time, exp_val, act_val));
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      report_failure($sformatf("** Error @ %0t: %s expected %b, got %b",
                               $time, name, exp_val, act_val));
    end
  endtask

  // Returns one cycle after frame_end_i was driven
  task automatic send_frame(input logic send_code, input logic [7:0] code,
                            input logic has_def, input logic [7:0] def_b);
    @(posedge clk_i);
    frame_start_i <= 1'b1;
    byte_i        <= code;
    byte_valid_i  <= send_code;
    if (has_def) begin
      @(posedge clk_i);
      frame_start_i <= 1'b0;
      byte_i        <= def_b;
      byte_valid_i  <= 1'b1;
    end
    @(posedge clk_i);
    frame_start_i <= 1'b0;
    byte_valid_i  <= 1'b0;
    frame_end_i   <= 1'b1;
    @(posedge clk_i);
    frame_end_i <= 1'b0;
  endtask

  task automatic watch_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk_i);
      check_flag("response_valid_o", 1'b0, response_valid_o);
      check_flag("enter_hdr_o", 1'b0, enter_hdr_o);
      check_rst_action(exp_rst, rst_action_o);
    end
  endtask

  task automatic wait_result(input result_e kind, input logic [7:0] exp_val,
                             input logic check_latency);
    int   elapsed;
    logic seen;
    elapsed = 0;
    seen    = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      elapsed++;
      if (elapsed > TIMEOUT) begin
        report_failure("expected pulse did not arrive");
      end
      case (kind)
        RES_RESP: seen = response_valid_o;
        RES_HDR:  seen = enter_hdr_o;
        default:  seen = (rst_action_o !== exp_rst);
      endcase
      if (!seen) begin
        check_flag("response_valid_o", 1'b0, response_valid_o);
        check_flag("enter_hdr_o", 1'b0, enter_hdr_o);
        check_rst_action(exp_rst, rst_action_o);
      end
    end
    if (check_latency && elapsed != 3) begin
      report_failure($sformatf("result came %0d cycles after frame end instead of 3", elapsed));
    end
    check_flag("response_valid_o", kind == RES_RESP, response_valid_o);
    check_flag("enter_hdr_o", kind == RES_HDR, enter_hdr_o);
    if (kind == RES_RESP) begin
      check_response(exp_val, response_byte_o);
    end
    if (kind == RES_RST) begin
      check_rst_action(exp_val, rst_action_o);
      exp_rst = exp_val;
    end
  endtask

  // Frames queue up behind the hold and only FIFO_DEPTH of them fit
  task automatic run_burst(input int count);
    queue_sizes_t sizes;
    logic [7:0]   code;
    sizes = next_sizes();
    // Equal fields would hide a reordering
    if (sizes.tx_buf == sizes.rx_buf) begin
      sizes.tx_buf = ~sizes.rx_buf;
    end
    exp_q.delete();
    @(posedge clk_i);
    queue_size_i    <= sizes;
    response_hold_i <= 1'b1;
    for (int i = 0; i < count; i++) begin
      code = (i % 2 == 0) ? CCC_GETMRL : CCC_GETMWL;
      send_frame(1'b1, code, 1'b0, 8'h00);
      if (i < FIFO_DEPTH) begin
        exp_q.push_back(expected_byte(code, sizes));
      end
    end
    watch_quiet(3);
    check_flag("overflow_o", count > FIFO_DEPTH, overflow_o);
    @(posedge clk_i);
    response_hold_i <= 1'b0;
    while (exp_q.size() != 0) begin
      wait_result(RES_RESP, exp_q.pop_front(), 1'b0);
    end
    watch_quiet(10);
    check_flag("overflow_o", count > FIFO_DEPTH, overflow_o);
  endtask

  initial begin
    row_t         row;
    queue_sizes_t sizes;
    logic [7:0]   exp_val;
    rst_ni          <= 1'b0;
    frame_start_i   <= 1'b0;
    byte_i          <= 8'h00;
    byte_valid_i    <= 1'b0;
    frame_end_i     <= 1'b0;
    response_hold_i <= 1'b0;
    queue_size_i    <= '0;
    rng_state = 32'd4991;
    exp_rst   = 8'h00;
    fill_table();
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("response_valid_o", 1'b0, response_valid_o);
    check_flag("enter_hdr_o", 1'b0, enter_hdr_o);
    check_flag("overflow_o", 1'b0, overflow_o);
    check_rst_action(8'h00, rst_action_o);
    for (int i = 0; i < NUM_ROWS; i++) begin
      row   = rows[i];
      sizes = next_sizes();
      @(posedge clk_i);
      queue_size_i    <= sizes;
      response_hold_i <= (row.hold_cycles != 0);
      send_frame(row.send_code, row.code, row.has_def, row.def_byte);
      exp_val = (row.kind == RES_RST) ? row.def_byte : expected_byte(row.code, sizes);
      if (row.kind == RES_NONE) begin
        watch_quiet(10);
      end else begin
        if (row.hold_cycles != 0) begin
          watch_quiet(int'(row.hold_cycles));
          @(posedge clk_i);
          response_hold_i <= 1'b0;
        end
        wait_result(row.kind, exp_val, row.hold_cycles == 0);
        watch_quiet(1);
      end
    end
    check_flag("overflow_o", 1'b0, overflow_o);
    run_burst(FIFO_DEPTH);
    run_burst(FIFO_DEPTH + 1);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== verification/tb_clock.sv ====
// Free-running clock with a period of 10 time units, low at time 0
module tb_clock (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #5 clk_o = ~clk_o;
  end

endmodule

// ==== src/ccc_top.sv ====
// Target-side CCC path; three cycles from frame end to result when the queue is empty and not held
module ccc_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  frame_start_i,
  input  logic [7:0]            byte_i,
  input  logic                  byte_valid_i,
  input  logic                  frame_end_i,
  input  logic                  response_hold_i,
  input  ccc_pkg::queue_sizes_t queue_size_i,
  output logic [7:0]            response_byte_o,
  output logic                  response_valid_o,
  output logic                  enter_hdr_o,
  output logic [7:0]            rst_action_o,
  output logic                  overflow_o
);

  import ccc_pkg::*;

  logic        push;
  ccc_record_t push_rec;
  logic        pop;
  ccc_record_t head_rec;
  logic        not_empty;

  ccc_frame_parser ccc_frame_parser_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .frame_start_i (frame_start_i),
    .byte_i        (byte_i),
    .byte_valid_i  (byte_valid_i),
    .frame_end_i   (frame_end_i),
    .push_o        (push),
    .push_rec_o    (push_rec)
  );

  ccc_record_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) ccc_record_fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .push_rec_i  (push_rec),
    .pop_i       (pop),
    .head_rec_o  (head_rec),
    .not_empty_o (not_empty),
    .overflow_o  (overflow_o)
  );

  ccc_handler ccc_handler_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .head_rec_i       (head_rec),
    .not_empty_i      (not_empty),
    .response_hold_i  (response_hold_i),
    .queue_size_i     (queue_size_i),
    .pop_o            (pop),
    .response_byte_o  (response_byte_o),
    .response_valid_o (response_valid_o),
    .enter_hdr_o      (enter_hdr_o),
    .rst_action_o     (rst_action_o)
  );

endmodule

// ==== src/ccc_handler.sv ====
// Single-byte responses only; codes other than GETMRL, GETMWL, ENTHDR0 and RSTACT are discarded
module ccc_handler (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ccc_pkg::ccc_record_t  head_rec_i,
  input  logic                  not_empty_i,
  input  logic                  response_hold_i,
  input  ccc_pkg::queue_sizes_t queue_size_i,
  output logic                  pop_o,
  output logic [7:0]            response_byte_o,
  output logic                  response_valid_o,
  output logic                  enter_hdr_o,
  output logic [7:0]            rst_action_o
);

  import ccc_pkg::*;

  logic       resp_valid_d;
  logic [7:0] resp_byte_d;
  logic       enter_hdr_d;
  logic       rst_load_d;

  logic       resp_valid_q;
  logic [7:0] resp_byte_q;
  logic       enter_hdr_q;
  logic [7:0] rst_action_q;

  // Head record is taken as soon as it shows up
  assign pop_o = not_empty_i && !response_hold_i;

  always_comb begin
    resp_valid_d = 1'b0;
    resp_byte_d  = 8'h00;
    enter_hdr_d  = 1'b0;
    rst_load_d   = 1'b0;
    if (pop_o) begin
      unique case (head_rec_i.code)
        CCC_GETMRL: begin
          resp_byte_d  = queue_size_i.rx_buf;
          resp_valid_d = 1'b1;
        end
        CCC_GETMWL: begin
          resp_byte_d  = queue_size_i.tx_buf;
          resp_valid_d = 1'b1;
        end
        CCC_ENTHDR0: begin
          enter_hdr_d = 1'b1;
        end
        CCC_RSTACT_BCAST, CCC_RSTACT_DIRECT: begin
          // Without a defining byte the action is kept
          rst_load_d = head_rec_i.def_valid;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      enter_hdr_q  <= 1'b0;
      rst_action_q <= 8'h00;
    end else begin
      resp_valid_q <= resp_valid_d;
      enter_hdr_q  <= enter_hdr_d;
      if (rst_load_d) begin
        rst_action_q <= head_rec_i.def_byte;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_valid_d) begin
      resp_byte_q <= resp_byte_d;
    end
  end

  assign response_byte_o  = resp_byte_q;
  assign response_valid_o = resp_valid_q;
  assign enter_hdr_o      = enter_hdr_q;
  assign rst_action_o     = rst_action_q;

  // A single record drives at most one kind of pulse
  single_pulse_kind_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(response_valid_o && enter_hdr_o)
  );

endmodule

// ==== src/ccc_record_fifo.sv ====
// FIFO_DEPTH must be a power of two of 2 or more; pushes into a full queue are lost
module ccc_record_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 push_i,
  input  ccc_pkg::ccc_record_t push_rec_i,
  input  logic                 pop_i,
  output ccc_pkg::ccc_record_t head_rec_o,
  output logic                 not_empty_o,
  output logic                 overflow_o
);

  import ccc_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

  ccc_record_t      mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             overflow_q;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full  = (count_q == FULL_CNT);
  // A pop on a full queue frees the slot for a push in the same cycle
  assign wr_en = push_i && (!full || pop_i);
  assign rd_en = pop_i && not_empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      if (push_i && !wr_en) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= push_rec_i;
    end
  end

  assign head_rec_o  = mem_q[rd_ptr_q];
  assign not_empty_o = (count_q != '0);
  assign overflow_o  = overflow_q;

  // Consumer must only pop a waiting record
  pop_not_empty_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> not_empty_o
  );

endmodule

// ==== src/ccc_frame_parser.sv ====
// Keeps only the first two bytes of a frame; stray bytes and frames without a code are dropped
module ccc_frame_parser (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                frame_start_i,
  input  logic [7:0]          byte_i,
  input  logic                byte_valid_i,
  input  logic                frame_end_i,
  output logic                push_o,
  output ccc_pkg::ccc_record_t push_rec_o
);

  import ccc_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CODE,
    ST_DEF,
    ST_DONE
  } state_e;

  state_e      state_q;
  ccc_record_t rec_q;
  logic        push_q;
  logic        have_code;

  // Code byte already seen in this frame
  assign have_code = (state_q == ST_DEF) || (state_q == ST_DONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      push_q  <= 1'b0;
    end else begin
      push_q <= 1'b0;
      if (frame_start_i) begin
        // A byte strobed with the start is taken as the code
        state_q <= byte_valid_i ? ST_DEF : ST_CODE;
      end else if (frame_end_i) begin
        push_q  <= have_code;
        state_q <= ST_IDLE;
      end else if (byte_valid_i) begin
        case (state_q)
          ST_CODE: state_q <= ST_DEF;
          ST_DEF:  state_q <= ST_DONE;
          default: state_q <= state_q;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (frame_start_i) begin
      rec_q.def_valid <= 1'b0;
      if (byte_valid_i) begin
        rec_q.code <= byte_i;
      end
    end else if (byte_valid_i && !frame_end_i) begin
      if (state_q == ST_CODE) begin
        rec_q.code <= byte_i;
      end else if (state_q == ST_DEF) begin
        rec_q.def_byte  <= byte_i;
        rec_q.def_valid <= 1'b1;
      end
    end
  end

  assign push_o     = push_q;
  assign push_rec_o = rec_q;

  // One record per frame, so pushes never come back to back
  push_single_cycle_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_o |=> !push_o
  );

endmodule

// ==== src/ccc_pkg.sv ====
// Shared CCC codes and record types; codes cover only the commands the handler decodes
package ccc_pkg;

  // Bit 7 of a command code marks a direct command
  localparam logic [7:0] CCC_ENTHDR0       = 8'h20;
  localparam logic [7:0] CCC_RSTACT_BCAST  = 8'h2A;
  localparam logic [7:0] CCC_RSTACT_DIRECT = 8'h9A;
  localparam logic [7:0] CCC_GETMWL        = 8'h8B;
  localparam logic [7:0] CCC_GETMRL        = 8'h8C;

  // One parsed frame, 17 bits
  typedef struct packed {
    logic [7:0] code;
    logic [7:0] def_byte;
    logic       def_valid;
  } ccc_record_t;

  // Buffer size word, most significant byte first
  typedef struct packed {
    logic [7:0] tx_buf;
    logic [7:0] rx_buf;
    logic [7:0] ibi_status;
    logic [7:0] cr_queue;
  } queue_sizes_t;

endpackage
